/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass message in the log
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f tb.f --top-module nlc_tb -o nlc_sim \
  && ./obj_dir/nlc_sim > sim.log 2>&1 \
  || { echo "Build or simulation error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "Test completed successfully" sim.log \
  && { echo "PASS"; exit 0; } \
  || { echo "FAIL"; exit 1; }

/* tb.f */
+incdir+include
verilog/nlc_format_pkg.sv
verilog/nlc_calib_pkg.sv
verilog/channel_capture.sv
verilog/normalize_stage.sv
verilog/horner_step.sv
verilog/result_store.sv
verilog/nlc_top.sv
testbench/nlc_tb.sv

/* include/nlc_tb_tasks.svh */
`ifndef NLC_TB_TASKS_SVH
`define NLC_TB_TASKS_SVH

localparam int OUT_MAX = 2 ** (SAMPLE_W - 1) - 1;
localparam int OUT_MIN = -(2 ** (SAMPLE_W - 1));

logic [31:0] lfsr_state = 32'hffe2;

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic lfsr_bit();
  logic fb;
  fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
  lfsr_state = {lfsr_state[30:0], fb};
  return fb;
endfunction

// n random bits, sign-extended from the top one
function automatic fix_t rand_signed(input int n);
  fix_t v;
  v = '0;
  for (int i = 0; i < n; i++)
    v = {v[30:0], lfsr_bit()};
  v = v <<< (FIX_W - n);
  return v >>> (FIX_W - n);
endfunction

function automatic fix_t ref_mul(input fix_t a, input fix_t b);
  logic signed [63:0] wide_a;
  logic signed [63:0] wide_b;
  logic signed [63:0] prod;
  wide_a = a;
  wide_b = b;
  prod = (wide_a * wide_b) >>> FRAC_BITS;
  return prod[31:0];
endfunction

function automatic sample_t ref_x_lin(input sample_t x, input fix_t nm, input fix_t rs,
                                      input coeff_vec_t c);
  fix_t ext;
  fix_t norm;
  fix_t acc;
  ext = fix_t'(x);
  ext = (ext <<< FRAC_BITS) + nm;
  norm = ref_mul(ext, rs);
  acc = c[POLY_ORDER];
  for (int k = POLY_ORDER - 1; k >= 0; k--)
    acc = ref_mul(acc, norm) + c[k];
  acc = acc >>> FRAC_BITS;
  if (acc > OUT_MAX)
    return sample_t'(OUT_MAX);
  if (acc < OUT_MIN)
    return sample_t'(OUT_MIN);
  return sample_t'(acc);
endfunction

task automatic check_sample(input string name, input sample_t got, input sample_t exp);
  if (got !== exp) begin
    $display("[ERROR] %s: got %h, expected %h", name, got, exp);
    fail_run();
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("[ERROR] %s: got %h, expected %h", name, got, exp);
    fail_run();
  end
endtask

task automatic check_count(input string name, input int got, input int exp);
  if (got != exp) begin
    $display("[ERROR] %s: got %h, expected %h", name, got, exp);
    fail_run();
  end
endtask

task automatic load_random();
  for (int i = 0; i < NUM_CH; i++) begin
    x_adc[i]       = sample_t'(rand_signed(8));
    neg_mean[i]    = rand_signed(18);
    recip_stdev[i] = rand_signed(14);
    for (int k = 0; k <= POLY_ORDER; k++)
      coeffs[i][k] = rand_signed(12);
  end
endtask

// Expected values from the data on the inputs, then one start pulse
task automatic start_run();
  for (int i = 0; i < NUM_CH; i++)
    exp_x[i] = ref_x_lin(x_adc[i], neg_mean[i], recip_stdev[i], coeffs[i]);
  @(negedge clk);
  srdyi = 1'b1;
  @(negedge clk);
  srdyi = 1'b0;
  check_bit("srdyo", srdyo, 1'b0);
endtask

// Cycles are counted from the start edge
task automatic finish_and_check(input int elapsed);
  int cycles;
  cycles = elapsed;
  while (srdyo !== 1'b1) begin
    @(negedge clk);
    cycles++;
    if (cycles > DONE_TIMEOUT) begin
      $display("Timeout: srdyo did not rise within %0d cycles", DONE_TIMEOUT);
      fail_run();
    end
  end
  check_count("srdyo latency", cycles, LATENCY);
  for (int i = 0; i < NUM_CH; i++)
    check_sample($sformatf("x_lin[%0d]", i), x_lin[i], exp_x[i]);
endtask

task automatic test_reset();
  check_bit("srdyo", srdyo, 1'b0);
  for (int i = 0; i < NUM_CH; i++)
    check_sample($sformatf("x_lin[%0d]", i), x_lin[i], '0);
endtask

task automatic test_identity();
  for (int i = 0; i < NUM_CH; i++) begin
    x_adc[i]       = sample_t'(9001 * i - 15000);
    neg_mean[i]    = '0;
    recip_stdev[i] = 32'sh0001_0000;
    coeffs[i]      = '0;
    coeffs[i][1]   = 32'sh0001_0000;
  end
  start_run();
  finish_and_check(0);
  for (int i = 0; i < NUM_CH; i++)
    check_sample($sformatf("x_lin[%0d]", i), x_lin[i], x_adc[i]);
endtask

task automatic test_random();
  repeat (3) begin
    load_random();
    start_run();
    finish_and_check(0);
  end
endtask

// Q16.16 integer part tops out at 16 bits, so the extremes are +-32768
task automatic test_saturation();
  for (int i = 0; i < NUM_CH; i++) begin
    x_adc[i]       = sample_t'(rand_signed(8));
    neg_mean[i]    = '0;
    recip_stdev[i] = 32'sh0001_0000;
    coeffs[i]      = '0;
    if (i < 2)
      coeffs[i][0] = (i == 0) ? 32'sh7fff_ffff : 32'sh8000_0000;
    else
      for (int k = 0; k <= POLY_ORDER; k++)
        coeffs[i][k] = rand_signed(31);
  end
  start_run();
  finish_and_check(0);
  check_sample("x_lin[0]", x_lin[0], sample_t'(32767));
  check_sample("x_lin[1]", x_lin[1], sample_t'(-32768));
endtask

task automatic test_restart();
  load_random();
  start_run();
  // New data and a start pulse mid-run, both ignored
  load_random();
  @(negedge clk);
  srdyi = 1'b1;
  @(negedge clk);
  srdyi = 1'b0;
  finish_and_check(2);
  start_run();
  finish_and_check(0);
endtask

`endif

/* testbench/nlc_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module nlc_tb
  import nlc_format_pkg::*;
  import nlc_calib_pkg::*;
();

  localparam int NUM_CH       = 4;
  localparam int LATENCY      = NUM_CH + POLY_ORDER + 3;
  localparam int DONE_TIMEOUT = 100;

  logic       clk;
  logic       rst;
  logic       srdyi;
  logic       srdyo;
  sample_t    x_adc       [NUM_CH];
  fix_t       neg_mean    [NUM_CH];
  fix_t       recip_stdev [NUM_CH];
  coeff_vec_t coeffs      [NUM_CH];
  sample_t    x_lin       [NUM_CH];
  sample_t    exp_x       [NUM_CH];

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  nlc_top #(
    .NUM_CHANNELS (NUM_CH)
  ) UUT (
    .clk         (clk),
    .rst         (rst),
    .srdyi       (srdyi),
    .srdyo       (srdyo),
    .x_adc       (x_adc),
    .neg_mean    (neg_mean),
    .recip_stdev (recip_stdev),
    .coeffs      (coeffs),
    .x_lin       (x_lin)
  );

  task automatic fail_run();
    $display("Test failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

`include "nlc_tb_tasks.svh"

  initial begin
    rst   = 1'b1;
    srdyi = 1'b0;
    for (int i = 0; i < NUM_CH; i++) begin
      x_adc[i]       = '0;
      neg_mean[i]    = '0;
      recip_stdev[i] = '0;
      coeffs[i]      = '0;
    end
    repeat (16) @(negedge clk);
    rst = 1'b0;

    test_reset();
    test_identity();
    test_random();
    test_saturation();
    test_restart();

    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/channel_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module channel_capture
  import nlc_format_pkg::*;
  import nlc_calib_pkg::*;
#(
  parameter int NUM_CHANNELS = 4,
  parameter int CHAN_W       = 2
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  input  logic              done,
  input  sample_t           x_adc       [NUM_CHANNELS],
  input  fix_t              neg_mean    [NUM_CHANNELS],
  input  fix_t              recip_stdev [NUM_CHANNELS],
  input  coeff_vec_t        coeffs      [NUM_CHANNELS],
  output logic              busy,
  output logic              issue_valid,
  output logic [CHAN_W-1:0] issue_chan,
  output sample_t           issue_sample,
  output fix_t              issue_neg_mean,
  output fix_t              issue_recip_stdev,
  output coeff_vec_t        issue_coeffs
);

  logic              busy_r;
  logic              issuing;
  logic              accept;
  logic [CHAN_W-1:0] cnt;

  sample_t    x_q  [NUM_CHANNELS];
  fix_t       nm_q [NUM_CHANNELS];
  fix_t       rs_q [NUM_CHANNELS];
  coeff_vec_t cf_q [NUM_CHANNELS];

  // Idle again as soon as the store reports done
  assign busy   = busy_r && !done;
  assign accept = start && !busy;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_r  <= 1'b0;
      issuing <= 1'b0;
      cnt     <= '0;
    end else if (accept) begin
      busy_r  <= 1'b1;
      issuing <= 1'b1;
      cnt     <= '0;
    end else begin
      if (done)
        busy_r <= 1'b0;
      if (issuing) begin
        if (cnt == CHAN_W'(NUM_CHANNELS - 1))
          issuing <= 1'b0;
        cnt <= cnt + 1'b1;
      end
    end
  end

  // Whole bank frozen for the run
  always_ff @(posedge clk) begin
    if (accept) begin
      x_q  <= x_adc;
      nm_q <= neg_mean;
      rs_q <= recip_stdev;
      cf_q <= coeffs;
    end
  end

  always_ff @(posedge clk) begin
    if (rst)
      issue_valid <= 1'b0;
    else
      issue_valid <= issuing;
  end

  always_ff @(posedge clk) begin
    issue_chan        <= cnt;
    issue_sample      <= x_q[cnt];
    issue_neg_mean    <= nm_q[cnt];
    issue_recip_stdev <= rs_q[cnt];
    issue_coeffs      <= cf_q[cnt];
  end

  a_chan_range: assert property (@(posedge clk) disable iff (rst)
    issue_valid |-> issue_chan < NUM_CHANNELS)
    else $error("channel_capture: issue_chan %0d out of range", issue_chan);

endmodule

`default_nettype wire

/* verilog/horner_step.sv */
`timescale 1ns/1ps
`default_nettype none

module horner_step
  import nlc_format_pkg::*;
  import nlc_calib_pkg::*;
#(
  parameter int CHAN_W = 2,
  parameter int STEP   = 0
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              in_valid,
  input  logic [CHAN_W-1:0] in_chan,
  input  fix_t              in_acc,
  input  fix_t              in_norm,
  input  coeff_vec_t        in_coeffs,
  output logic              out_valid,
  output logic [CHAN_W-1:0] out_chan,
  output fix_t              out_acc,
  output fix_t              out_norm,
  output coeff_vec_t        out_coeffs
);

  fix_t coeff;

  if (STEP < 0 || STEP >= POLY_ORDER) begin : g_bad_step
    $error("horner_step: STEP %0d outside 0..%0d", STEP, POLY_ORDER - 1);
  end

  assign coeff = in_coeffs[STEP];

  always_ff @(posedge clk) begin
    if (rst)
      out_valid <= 1'b0;
    else
      out_valid <= in_valid;
  end

  // acc * x + a_k, wraps to 32 bits
  always_ff @(posedge clk) begin
    out_chan   <= in_chan;
    out_acc    <= fix_mul(in_acc, in_norm) + coeff;
    out_norm   <= in_norm;
    out_coeffs <= in_coeffs;
  end

endmodule

`default_nettype wire

/* verilog/nlc_calib_pkg.sv */
`default_nettype none

package nlc_calib_pkg;

  import nlc_format_pkg::*;

  localparam int POLY_ORDER = 5;
  localparam int NUM_COEFFS = POLY_ORDER + 1;

  // Element k holds the coefficient of x^k
  typedef fix_t [NUM_COEFFS-1:0] coeff_vec_t;

endpackage

`default_nettype wire

/* verilog/nlc_format_pkg.sv */
`default_nettype none

package nlc_format_pkg;

  localparam int SAMPLE_W  = 21;
  localparam int FIX_W     = 32;
  localparam int FRAC_BITS = 16;

  // Limits of the corrected output
  localparam int SAMPLE_MAX = (1 << (SAMPLE_W - 1)) - 1;
  localparam int SAMPLE_MIN = -(1 << (SAMPLE_W - 1));

  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // Q16.16
  typedef logic signed [FIX_W-1:0] fix_t;

  // Full product, rescaled and truncated back to Q16.16
  function automatic fix_t fix_mul(input fix_t a, input fix_t b);
    logic signed [2*FIX_W-1:0] prod;
    prod = a * b;
    return prod[FRAC_BITS +: FIX_W];
  endfunction

endpackage

`default_nettype wire

/* verilog/nlc_top.sv */
`timescale 1ns/1ps
`default_nettype none

module nlc_top
  import nlc_format_pkg::*;
  import nlc_calib_pkg::*;
#(
  parameter int NUM_CHANNELS = 4
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       srdyi,
  output logic       srdyo,
  input  sample_t    x_adc       [NUM_CHANNELS],
  input  fix_t       neg_mean    [NUM_CHANNELS],
  input  fix_t       recip_stdev [NUM_CHANNELS],
  input  coeff_vec_t coeffs      [NUM_CHANNELS],
  output sample_t    x_lin       [NUM_CHANNELS]
);

  localparam int CHAN_W = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1;

  logic              busy;
  logic              store_start;

  logic              issue_valid;
  logic [CHAN_W-1:0] issue_chan;
  sample_t           issue_sample;
  fix_t              issue_neg_mean;
  fix_t              issue_recip_stdev;
  coeff_vec_t        issue_coeffs;

  // Index 0 is the normalizer output, POLY_ORDER the last Horner step
  logic              step_valid  [POLY_ORDER+1];
  logic [CHAN_W-1:0] step_chan   [POLY_ORDER+1];
  fix_t              step_acc    [POLY_ORDER+1];
  fix_t              step_norm   [POLY_ORDER+1];
  coeff_vec_t        step_coeffs [POLY_ORDER+1];

  // Start reaches the store only when the engine is idle
  assign store_start = srdyi && !busy;

  channel_capture #(
    .NUM_CHANNELS (NUM_CHANNELS),
    .CHAN_W       (CHAN_W)
  ) u_capture (
    .clk               (clk),
    .rst               (rst),
    .start             (srdyi),
    .done              (srdyo),
    .x_adc             (x_adc),
    .neg_mean          (neg_mean),
    .recip_stdev       (recip_stdev),
    .coeffs            (coeffs),
    .busy              (busy),
    .issue_valid       (issue_valid),
    .issue_chan        (issue_chan),
    .issue_sample      (issue_sample),
    .issue_neg_mean    (issue_neg_mean),
    .issue_recip_stdev (issue_recip_stdev),
    .issue_coeffs      (issue_coeffs)
  );

  normalize_stage #(
    .CHAN_W (CHAN_W)
  ) u_normalize (
    .clk            (clk),
    .rst            (rst),
    .in_valid       (issue_valid),
    .in_chan        (issue_chan),
    .in_sample      (issue_sample),
    .in_neg_mean    (issue_neg_mean),
    .in_recip_stdev (issue_recip_stdev),
    .in_coeffs      (issue_coeffs),
    .out_valid      (step_valid[0]),
    .out_chan       (step_chan[0]),
    .out_norm       (step_norm[0]),
    .out_coeffs     (step_coeffs[0])
  );

  // Horner seed is the highest-order coefficient
  assign step_acc[0] = step_coeffs[0][POLY_ORDER];

  for (genvar i = 0; i < POLY_ORDER; i++) begin : g_horner
    horner_step #(
      .CHAN_W (CHAN_W),
      .STEP   (POLY_ORDER - 1 - i)
    ) u_step (
      .clk        (clk),
      .rst        (rst),
      .in_valid   (step_valid[i]),
      .in_chan    (step_chan[i]),
      .in_acc     (step_acc[i]),
      .in_norm    (step_norm[i]),
      .in_coeffs  (step_coeffs[i]),
      .out_valid  (step_valid[i+1]),
      .out_chan   (step_chan[i+1]),
      .out_acc    (step_acc[i+1]),
      .out_norm   (step_norm[i+1]),
      .out_coeffs (step_coeffs[i+1])
    );
  end

  result_store #(
    .NUM_CHANNELS (NUM_CHANNELS),
    .CHAN_W       (CHAN_W)
  ) u_store (
    .clk      (clk),
    .rst      (rst),
    .start    (store_start),
    .in_valid (step_valid[POLY_ORDER]),
    .in_chan  (step_chan[POLY_ORDER]),
    .in_acc   (step_acc[POLY_ORDER]),
    .x_lin    (x_lin),
    .done     (srdyo)
  );

endmodule

`default_nettype wire

/* verilog/normalize_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module normalize_stage
  import nlc_format_pkg::*;
  import nlc_calib_pkg::*;
#(
  parameter int CHAN_W = 2
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              in_valid,
  input  logic [CHAN_W-1:0] in_chan,
  input  sample_t           in_sample,
  input  fix_t              in_neg_mean,
  input  fix_t              in_recip_stdev,
  input  coeff_vec_t        in_coeffs,
  output logic              out_valid,
  output logic [CHAN_W-1:0] out_chan,
  output fix_t              out_norm,
  output coeff_vec_t        out_coeffs
);

  logic              ofs_valid;
  logic [CHAN_W-1:0] ofs_chan;
  fix_t              ofs_sum;
  fix_t              ofs_recip;
  coeff_vec_t        ofs_coeffs;
  fix_t              sample_fix;

  // Sample moved to Q16.16, upper bits wrap
  assign sample_fix = fix_t'(fix_t'(in_sample) <<< FRAC_BITS);

  always_ff @(posedge clk) begin
    if (rst) begin
      ofs_valid <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      ofs_valid <= in_valid;
      out_valid <= ofs_valid;
    end
  end

  // Offset
  always_ff @(posedge clk) begin
    ofs_chan   <= in_chan;
    ofs_sum    <= sample_fix + in_neg_mean;
    ofs_recip  <= in_recip_stdev;
    ofs_coeffs <= in_coeffs;
  end

  // Scale
  always_ff @(posedge clk) begin
    out_chan   <= ofs_chan;
    out_norm   <= fix_mul(ofs_sum, ofs_recip);
    out_coeffs <= ofs_coeffs;
  end

endmodule

`default_nettype wire

/* verilog/result_store.sv */
`timescale 1ns/1ps
`default_nettype none

module result_store
  import nlc_format_pkg::*;
#(
  parameter int NUM_CHANNELS = 4,
  parameter int CHAN_W       = 2
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  input  logic              in_valid,
  input  logic [CHAN_W-1:0] in_chan,
  input  fix_t              in_acc,
  output sample_t           x_lin [NUM_CHANNELS],
  output logic              done
);

  logic [CHAN_W-1:0] wr_cnt;
  logic              last_wr;
  fix_t              int_val;
  fix_t              sat_val;

  // Integer part of the polynomial result
  assign int_val = in_acc >>> FRAC_BITS;
  assign last_wr = in_valid && (wr_cnt == CHAN_W'(NUM_CHANNELS - 1));

  always_comb begin
    if (int_val > SAMPLE_MAX)
      sat_val = SAMPLE_MAX;
    else if (int_val < SAMPLE_MIN)
      sat_val = SAMPLE_MIN;
    else
      sat_val = int_val;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_cnt <= '0;
      done   <= 1'b0;
      for (int i = 0; i < NUM_CHANNELS; i++)
        x_lin[i] <= '0;
    end else if (start) begin
      wr_cnt <= '0;
      done   <= 1'b0;
    end else if (in_valid) begin
      x_lin[in_chan] <= sample_t'(sat_val);
      wr_cnt         <= last_wr ? '0 : wr_cnt + 1'b1;
      // Done with the last channel of the run
      if (last_wr)
        done <= 1'b1;
    end
  end

  a_in_order: assert property (@(posedge clk) disable iff (rst)
    in_valid |-> in_chan == wr_cnt)
    else $error("result_store: channel %0d arrived, expected %0d", in_chan, wr_cnt);

endmodule

`default_nettype wire
